/* files.f */
+incdir+.
lsu_bus_pkg.sv
lsu_op_pkg.sv
lsu_req_if.sv
lsu_store_prep.sv
lsu_ctrl.sv
lsu_load_align.sv
lsu_top.sv
tb_lsu.sv

/* lsu_bus_pkg.sv */
/* data bus sizing and the shared view of one bus word
   assumes a little-endian 32-bit bus with byte lane 0 at bits 7:0
   addresses on the bus are always word aligned */

package lsu_bus_pkg;

  ////////////////////
  // sizes
  ////////////////////

  localparam int unsigned BUS_W  = 32;             // data and address width
  localparam int unsigned BYTE_W = 8;              // one byte lane
  localparam int unsigned HALF_W = 16;             // one halfword lane
  localparam int unsigned BE_W   = BUS_W / BYTE_W; // byte lanes per word, 4

  ////////////////////
  // word types
  ////////////////////

  // plain bus word, used for addresses as well as data
  typedef logic [BUS_W-1:0] bus_word_t;

  // one enable bit per byte lane
  typedef logic [BE_W-1:0] be_t;

  // returned read word, picked apart by the load aligner
  // bytes[0] and halves[0] sit at the low end of the word
  typedef union packed {
    logic [BE_W-1:0][BYTE_W-1:0]           bytes;  // four byte lanes
    logic [BUS_W/HALF_W-1:0][HALF_W-1:0]   halves; // two halfword lanes
  } bus_word_u;

endpackage

/* lsu_ctrl.sv */
/* bus sequencing FSM, one access at a time
   a split access has its second request out before the first rvalid,
   so up to two parts are in flight; the bus must answer in order */

`timescale 1ns/1ps

module lsu_ctrl (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      lsu_req_i,      // level request from execute
  input  logic      lsu_we_i,
  output logic      data_req_o,
  input  logic      data_gnt_i,
  input  logic      data_rvalid_i,
  input  logic      data_err_i,
  output logic      lsu_req_done_o, // last part granted
  output logic      busy_o,
  lsu_req_if.ctrl   req,
  lsu_align_if.ctrl aln
);

  typedef enum logic [2:0] {
    S_IDLE,        // nothing waiting for a grant
    S_GNT_MIS,     // first part of a split waits for grant
    S_RVALID_MIS,  // second part requested, first rvalid pending
    S_GNT,         // last part waits for grant
    S_RVALID_DONE  // both granted, first rvalid pending
  } state_e;

  state_e state_q, state_d;
  logic   second_q, second_d; // address points at the upper word
  logic   err_q, err_d;       // first part came back with an error
  logic   last_gnt;           // final bus part granted this cycle

  ////////////////////
  // next state
  ////////////////////

  always_comb begin
    state_d             = state_q;
    second_d            = second_q;
    err_d               = err_q;
    data_req_o          = 1'b0;
    last_gnt            = 1'b0;
    aln.capture         = 1'b0;
    aln.first_rdata_upd = 1'b0;

    unique case (state_q)
      S_IDLE: begin
        if (lsu_req_i) begin
          data_req_o = 1'b1;
          err_d      = 1'b0; // fresh access
          if (data_gnt_i) begin
            aln.capture = 1'b1;
            second_d    = req.split;
            last_gnt    = ~req.split;
            state_d     = req.split ? S_RVALID_MIS : S_IDLE;
          end else begin
            state_d     = req.split ? S_GNT_MIS : S_GNT;
          end
        end
      end

      S_GNT_MIS: begin
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          aln.capture = 1'b1;
          second_d    = 1'b1; // switch over to the upper word
          state_d     = S_RVALID_MIS;
        end
      end

      S_RVALID_MIS: begin
        data_req_o = 1'b1;       // upper word goes out right away
        last_gnt   = data_gnt_i;
        if (data_rvalid_i) begin
          err_d               = data_err_i;
          aln.first_rdata_upd = 1'b1;
          second_d            = ~data_gnt_i;
          state_d             = data_gnt_i ? S_IDLE : S_GNT;
        end else if (data_gnt_i) begin
          second_d = 1'b0;
          state_d  = S_RVALID_DONE;
        end
      end

      S_GNT: begin
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          aln.capture = 1'b1; // inputs still held, same values on a split
          last_gnt    = 1'b1;
          second_d    = 1'b0;
          state_d     = S_IDLE;
        end
      end

      S_RVALID_DONE: begin
        if (data_rvalid_i) begin
          err_d               = data_err_i;
          aln.first_rdata_upd = 1'b1;
          state_d             = S_IDLE; // second rvalid arrives in idle
        end
      end

      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= S_IDLE;
      second_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      state_q  <= state_d;
      second_q <= second_d;
      err_q    <= err_d;
    end
  end

  ////////////////////
  // outputs
  ////////////////////

  assign lsu_req_done_o  = last_gnt; // execute may drop its fields after this
  assign busy_o          = (state_q != S_IDLE);
  assign req.second_part = second_q;
  assign aln.first_err   = err_q;
  assign aln.final_resp  = (state_q == S_IDLE);
  assign aln.offset      = req.offset;

  state_legal_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      state_q inside {S_IDLE, S_GNT_MIS, S_RVALID_MIS, S_GNT, S_RVALID_DONE});

  addr_known_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      data_req_o |-> !$isunknown(req.word_addr));

  // execute keeps the request up and unchanged until the last grant
  req_held_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (lsu_req_i && !lsu_req_done_o) |=> (lsu_req_i && $stable(lsu_we_i)));

endmodule

/* lsu_load_align.sv */
/* response side, realigns and extends load data
   attributes are latched on grant, so a new access must not be granted
   before the previous response has come back */

`timescale 1ns/1ps

module lsu_load_align (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      lsu_sign_ext_i,
  input  lsu_op_pkg::access_size_e  lsu_size_i,
  input  logic                      lsu_we_i,
  input  lsu_bus_pkg::bus_word_t    data_rdata_i,
  input  logic                      data_rvalid_i,
  input  logic                      data_err_i,
  lsu_align_if.align                aln,
  output lsu_bus_pkg::bus_word_t    lsu_rdata_o,
  output logic                      lsu_resp_valid_o,
  output logic                      lsu_rdata_valid_o,
  output logic                      load_err_o,
  output logic                      store_err_o
);

  lsu_op_pkg::offset_t      offset_q;
  lsu_op_pkg::access_size_e size_q;
  logic                     sign_q;
  logic                     we_q;
  logic [lsu_bus_pkg::BE_W-2:0][lsu_bus_pkg::BYTE_W-1:0] hi_q; // first word, lanes 3..1

  lsu_bus_pkg::bus_word_u           rd;     // current read word by lanes
  lsu_bus_pkg::bus_word_t           word_w;
  logic [lsu_bus_pkg::HALF_W-1:0]   half_w;
  logic [lsu_bus_pkg::BYTE_W-1:0]   byte_w;
  logic                             err;

  ////////////////////
  // captured state
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offset_q <= '0;
      size_q   <= lsu_op_pkg::WORD;
      sign_q   <= 1'b0;
      we_q     <= 1'b0;
    end else if (aln.capture) begin
      offset_q <= aln.offset;
      size_q   <= lsu_size_i;
      sign_q   <= lsu_sign_ext_i;
      we_q     <= lsu_we_i;
    end
  end

  // lane 0 of the first word never reaches a split result
  always_ff @(posedge clk_i) begin
    if (aln.first_rdata_upd && !we_q) begin
      hi_q <= data_rdata_i[lsu_bus_pkg::BUS_W-1:lsu_bus_pkg::BYTE_W];
    end
  end

  ////////////////////
  // lane select
  ////////////////////

  assign rd = data_rdata_i;

  always_comb begin
    unique case (offset_q)
      2'd0:    word_w = rd;
      2'd1:    word_w = {rd.bytes[0], hi_q[2], hi_q[1], hi_q[0]};
      2'd2:    word_w = {rd.bytes[1], rd.bytes[0], hi_q[2], hi_q[1]};
      default: word_w = {rd.bytes[2], rd.bytes[1], rd.bytes[0], hi_q[2]};
    endcase
  end

  always_comb begin
    unique case (offset_q)
      2'd0:    half_w = rd.halves[0];
      2'd1:    half_w = {rd.bytes[2], rd.bytes[1]};
      2'd2:    half_w = rd.halves[1];
      default: half_w = {rd.bytes[0], hi_q[2]}; // low byte from the first word
    endcase
  end

  assign byte_w = rd.bytes[offset_q]; // bytes never split

  // zero or sign extension, code 3 falls through to byte
  always_comb begin
    unique case (size_q)
      lsu_op_pkg::WORD: lsu_rdata_o = word_w;
      lsu_op_pkg::HALF: lsu_rdata_o = {{(lsu_bus_pkg::BUS_W - lsu_bus_pkg::HALF_W)
                                        {sign_q & half_w[lsu_bus_pkg::HALF_W-1]}}, half_w};
      default:          lsu_rdata_o = {{(lsu_bus_pkg::BUS_W - lsu_bus_pkg::BYTE_W)
                                        {sign_q & byte_w[lsu_bus_pkg::BYTE_W-1]}}, byte_w};
    endcase
  end

  ////////////////////
  // response
  ////////////////////

  assign err               = aln.first_err | data_err_i; // either part failed
  assign lsu_resp_valid_o  = data_rvalid_i & aln.final_resp;
  assign lsu_rdata_valid_o = lsu_resp_valid_o & ~err & ~we_q;
  assign load_err_o        = lsu_resp_valid_o & err & ~we_q;
  assign store_err_o       = lsu_resp_valid_o & err & we_q;

  // a grant with unknown execute fields would poison the whole response
  attr_known_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      !$isunknown({offset_q, size_q, sign_q, we_q}));

endmodule

/* lsu_op_pkg.sv */
/* access sizes and the rule for splitting an access into two words
   size code 3 is not named and is handled as a byte access
   a split access always moves on to the next word, never wraps */

package lsu_op_pkg;

  ////////////////////
  // access size
  ////////////////////

  // encoding matches the execute stage: 00 word, 01 half, 1x byte
  typedef enum logic [1:0] {
    WORD = 2'b00,
    HALF = 2'b01,
    BYTE = 2'b10
  } access_size_e;

  // byte position inside a word
  typedef logic [1:0] offset_t;

  ////////////////////
  // split rule
  ////////////////////

  // a word access splits at any offset other than this one
  localparam offset_t ALIGNED_OFFSET = 2'd0;

  // a halfword only crosses into the next word from the top byte lane
  localparam offset_t HALF_SPLIT_OFFSET = 2'd3;

  // byte distance from the first word address to the second
  localparam int unsigned WORD_STEP = 4;

endpackage

/* lsu_req_if.sv */
/* internal links of the load/store unit
   lsu_req_if carries the prepared bus request, lsu_align_if the
   capture strobes from the FSM to the load aligner */

`timescale 1ns/1ps

interface lsu_req_if (
  input logic clk_i,
  input logic rst_ni
);
  lsu_bus_pkg::bus_word_t word_addr;   // word aligned bus address
  lsu_bus_pkg::be_t       be;          // byte enables for this part
  lsu_bus_pkg::bus_word_t wdata;       // write data rotated onto its lanes
  logic                   split;       // access needs two bus words
  lsu_op_pkg::offset_t    offset;      // byte offset of the request address
  logic                   second_part; // FSM is on the upper word

  modport prep (input clk_i, rst_ni, second_part,
                output word_addr, be, wdata, split, offset);
  modport ctrl (input word_addr, split, offset, output second_part);
endinterface

interface lsu_align_if;
  logic                capture;         // grant seen, latch access attributes
  logic                first_rdata_upd; // first rvalid of a split access
  logic                first_err;       // bus error seen on the first part
  logic                final_resp;      // FSM idle, next rvalid is the last one
  lsu_op_pkg::offset_t offset;          // offset forwarded for the capture

  modport ctrl  (output capture, first_rdata_upd, first_err, final_resp, offset);
  modport align (input capture, first_rdata_upd, first_err, final_resp, offset);
endinterface

/* lsu_store_prep.sv */
/* request side, purely combinational
   address, size and write data must be held by the execute stage
   until done, the second part relies on them staying put */

`timescale 1ns/1ps

module lsu_store_prep (
  input  lsu_bus_pkg::bus_word_t    lsu_addr_i,  // byte address from the ALU
  input  lsu_op_pkg::access_size_e  lsu_size_i,
  input  lsu_bus_pkg::bus_word_t    lsu_wdata_i, // store data, lane 0 aligned
  lsu_req_if.prep                   req
);

  lsu_bus_pkg::bus_word_t base_addr;  // word holding the first byte
  lsu_op_pkg::offset_t    offset;

  assign offset     = lsu_addr_i[1:0];
  assign base_addr  = {lsu_addr_i[lsu_bus_pkg::BUS_W-1:2], 2'b00};
  assign req.offset = offset;

  // second part goes to the following word, no help needed from execute
  assign req.word_addr = req.second_part ?
      base_addr + lsu_bus_pkg::bus_word_t'(lsu_op_pkg::WORD_STEP) : base_addr;

  ////////////////////
  // split detection
  ////////////////////

  assign req.split =
      ((lsu_size_i == lsu_op_pkg::WORD) && (offset != lsu_op_pkg::ALIGNED_OFFSET)) ||
      ((lsu_size_i == lsu_op_pkg::HALF) && (offset == lsu_op_pkg::HALF_SPLIT_OFFSET));

  ////////////////////
  // byte enables
  ////////////////////

  // shifted masks give the usual table, e.g. word at offset 2 is
  // 1100 on the first part and 0011 on the second
  always_comb begin
    unique case (lsu_size_i)
      lsu_op_pkg::WORD: begin
        if (req.second_part) begin
          req.be = ~lsu_bus_pkg::be_t'(4'b1111 << offset); // lanes left over
        end else begin
          req.be = lsu_bus_pkg::be_t'(4'b1111 << offset);
        end
      end
      lsu_op_pkg::HALF: begin
        if (req.second_part) begin
          req.be = 4'b0001;                               // only offset 3 splits
        end else begin
          req.be = lsu_bus_pkg::be_t'(4'b0011 << offset); // top bit drops at 3
        end
      end
      default: req.be = lsu_bus_pkg::be_t'(4'b0001 << offset); // byte, codes 2 and 3
    endcase
  end

  ////////////////////
  // write data
  ////////////////////

  // rotate left by the offset, bytes that wrap land on the second word
  always_comb begin
    unique case (offset)
      2'd0:    req.wdata = lsu_wdata_i;
      2'd1:    req.wdata = {lsu_wdata_i[23:0], lsu_wdata_i[31:24]};
      2'd2:    req.wdata = {lsu_wdata_i[15:0], lsu_wdata_i[31:16]};
      default: req.wdata = {lsu_wdata_i[7:0],  lsu_wdata_i[31:8]};
    endcase
  end

  // the FSM only sets second_part on held split requests, so a known
  // request never yields an empty lane mask
  be_nonzero_a: assert property (@(posedge req.clk_i) disable iff (!req.rst_ni)
      !$isunknown({lsu_addr_i, lsu_size_i}) |-> (req.be != '0));

  addr_aligned_a: assert property (@(posedge req.clk_i) disable iff (!req.rst_ni)
      !$isunknown(lsu_addr_i) |-> (req.word_addr[1:0] == 2'b00));

endmodule

/* lsu_top.sv */
/* load/store unit top, one access at a time on a req/gnt/rvalid bus
   execute holds lsu_req_i and its fields until lsu_req_done_o
   at most two bus requests outstanding, answered in order */

`timescale 1ns/1ps

module lsu_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // data bus
  output logic                      data_req_o,
  input  logic                      data_gnt_i,
  input  logic                      data_rvalid_i,
  input  logic                      data_err_i,
  output lsu_bus_pkg::bus_word_t    data_addr_o,   // always word aligned
  output logic                      data_we_o,
  output lsu_bus_pkg::be_t          data_be_o,
  output lsu_bus_pkg::bus_word_t    data_wdata_o,
  input  lsu_bus_pkg::bus_word_t    data_rdata_i,
  // execute side
  input  logic                      lsu_req_i,
  input  logic                      lsu_we_i,
  input  lsu_op_pkg::access_size_e  lsu_size_i,
  input  lsu_bus_pkg::bus_word_t    lsu_addr_i,
  input  lsu_bus_pkg::bus_word_t    lsu_wdata_i,
  input  logic                      lsu_sign_ext_i,
  output lsu_bus_pkg::bus_word_t    lsu_rdata_o,
  output logic                      lsu_rdata_valid_o,
  output logic                      lsu_req_done_o,
  output logic                      lsu_resp_valid_o,
  output logic                      load_err_o,
  output logic                      store_err_o,
  output logic                      busy_o
);

  lsu_req_if   req_bus (.clk_i(clk_i), .rst_ni(rst_ni));
  lsu_align_if aln_bus ();

  // prepared request straight onto the bus
  assign data_addr_o  = req_bus.word_addr;
  assign data_be_o    = req_bus.be;
  assign data_wdata_o = req_bus.wdata;
  assign data_we_o    = lsu_we_i;

  lsu_store_prep u_prep (
    .lsu_addr_i  (lsu_addr_i),
    .lsu_size_i  (lsu_size_i),
    .lsu_wdata_i (lsu_wdata_i),
    .req         (req_bus.prep)
  );

  lsu_ctrl u_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .lsu_req_i      (lsu_req_i),
    .lsu_we_i       (lsu_we_i),
    .data_req_o     (data_req_o),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i),
    .data_err_i     (data_err_i),
    .lsu_req_done_o (lsu_req_done_o),
    .busy_o         (busy_o),
    .req            (req_bus.ctrl),
    .aln            (aln_bus.ctrl)
  );

  lsu_load_align u_align (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .lsu_sign_ext_i    (lsu_sign_ext_i),
    .lsu_size_i        (lsu_size_i),
    .lsu_we_i          (lsu_we_i),
    .data_rdata_i      (data_rdata_i),
    .data_rvalid_i     (data_rvalid_i),
    .data_err_i        (data_err_i),
    .aln               (aln_bus.align),
    .lsu_rdata_o       (lsu_rdata_o),
    .lsu_resp_valid_o  (lsu_resp_valid_o),
    .lsu_rdata_valid_o (lsu_rdata_valid_o),
    .load_err_o        (load_err_o),
    .store_err_o       (store_err_o)
  );

endmodule

/* tb_lsu_ref.svh */
/* reference rules for the load/store unit testbench
   included inside tb_lsu, works on its exp_mem copy of memory
   memory is 256 bytes, byte addresses wrap at 0x100 */

`ifndef TB_LSU_REF_SVH
`define TB_LSU_REF_SVH

////////////////////
// access rules
////////////////////

function automatic int size_bytes(input lsu_op_pkg::access_size_e s);
  case (s)
    lsu_op_pkg::WORD: return 4;
    lsu_op_pkg::HALF: return 2;
    default:          return 1; // byte for both codes
  endcase
endfunction

function automatic logic [7:0] byte_at(input lsu_bus_pkg::bus_word_t a);
  return exp_mem[a[7:2]][8*a[1:0] +: 8];
endfunction

// top 16 bytes of memory answer with a bus error
function automatic logic in_err_range(input lsu_bus_pkg::bus_word_t a);
  return a[7:4] == 4'hf;
endfunction

// two parts once the bytes run past the end of the first word
function automatic int part_count(input lsu_bus_pkg::bus_word_t a,
                                  input lsu_op_pkg::access_size_e s);
  return (int'(a[1:0]) + size_bytes(s) > 4) ? 2 : 1;
endfunction

function automatic lsu_bus_pkg::be_t lane_enables(input lsu_bus_pkg::bus_word_t a,
                                                  input lsu_op_pkg::access_size_e s,
                                                  input int unsigned part);
  logic [7:0] m; // lanes over two words
  m = ((8'd1 << size_bytes(s)) - 8'd1) << a[1:0];
  return (part == 0) ? m[3:0] : m[7:4];
endfunction

function automatic logic access_errors(input lsu_bus_pkg::bus_word_t a,
                                       input lsu_op_pkg::access_size_e s);
  return in_err_range(a) || (part_count(a, s) == 2 && in_err_range(a + 4));
endfunction

// little endian gather, then zero or sign extension
function automatic lsu_bus_pkg::bus_word_t loaded_value(input lsu_bus_pkg::bus_word_t a,
                                                        input lsu_op_pkg::access_size_e s,
                                                        input logic sign);
  lsu_bus_pkg::bus_word_t v;
  int n;
  n = size_bytes(s);
  v = '0;
  for (int i = 0; i < n; i++) v[8*i +: 8] = byte_at(a + i);
  if (sign && n < 4) begin
    for (int i = 8 * n; i < 32; i++) v[i] = v[8*n-1];
  end
  return v;
endfunction

// bytes landing in the error range are dropped by the bus
task automatic apply_store(input lsu_bus_pkg::bus_word_t a,
                           input lsu_op_pkg::access_size_e s,
                           input lsu_bus_pkg::bus_word_t wd);
  lsu_bus_pkg::bus_word_t b;
  for (int i = 0; i < size_bytes(s); i++) begin
    b = a + i;
    if (!in_err_range(b)) exp_mem[b[7:2]][8*b[1:0] +: 8] = wd[8*i +: 8];
  end
endtask

////////////////////
// compare tasks
////////////////////

task automatic check_word(input string what, input lsu_bus_pkg::bus_word_t got,
                          input lsu_bus_pkg::bus_word_t exp);
  if (got !== exp) begin
    stop_on_error($sformatf("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp));
  end
endtask

task automatic check_be(input string what, input lsu_bus_pkg::be_t got,
                        input lsu_bus_pkg::be_t exp);
  if (got !== exp) begin
    stop_on_error($sformatf("FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp));
  end
endtask

task automatic check_flag(input string what, input bit got, input bit exp);
  if (got != exp) begin
    stop_on_error($sformatf("FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp));
  end
endtask

`endif

/* tb_lsu.sv */
/* testbench for lsu_top with an in-order bus memory model
   one access at a time, the next one starts after the response
   256-byte memory, bytes 0xf0..0xff answer with a bus error */

`timescale 1ns/1ps

module tb_lsu;

  localparam int unsigned N_RAND = 60;                    // random mixed accesses
  localparam int unsigned N_ACC  = 24 + 24 + N_RAND + 15; // all phases together

  logic                     clk_i, rst_ni;
  logic                     data_req_o, data_gnt_i, data_rvalid_i, data_err_i, data_we_o;
  lsu_bus_pkg::bus_word_t   data_addr_o, data_wdata_o, data_rdata_i;
  lsu_bus_pkg::be_t         data_be_o;
  logic                     lsu_req_i, lsu_we_i, lsu_sign_ext_i;
  lsu_op_pkg::access_size_e lsu_size_i;
  lsu_bus_pkg::bus_word_t   lsu_addr_i, lsu_wdata_i, lsu_rdata_o;
  logic                     lsu_rdata_valid_o, lsu_req_done_o, lsu_resp_valid_o;
  logic                     load_err_o, store_err_o, busy_o;

  lsu_bus_pkg::bus_word_t   mem [64];     // bus side memory
  lsu_bus_pkg::bus_word_t   exp_mem [64]; // what memory should hold

  // access in flight
  lsu_bus_pkg::bus_word_t   cur_addr, cur_wdata;
  lsu_op_pkg::access_size_e cur_size;
  logic                     cur_we, cur_sign;

  int                       seed = 32'h838a;
  int unsigned              n_gnt, n_done;
  int unsigned              cyc, last_ready, gnt_wait;
  int unsigned              ready_q [$]; // cycle of each pending rvalid
  lsu_bus_pkg::bus_word_t   rdata_q [$];
  logic                     err_q [$];

  lsu_top dut0 (.*);

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("Something failed");
    $fatal(1, "stopped at the first error");
  endtask

  function automatic int unsigned pick(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  `include "tb_lsu_ref.svh"

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // each access fits well inside 20 cycles even when split on a slow bus
  initial begin : watchdog
    repeat (N_ACC * 20 + 10) @(posedge clk_i);
    stop_on_error("watchdog expired, the unit stopped answering");
  end

  ////////////////////
  // bus memory model
  ////////////////////

  initial begin : bus_model
    int unsigned ready;
    logic        err;
    forever begin
      @(posedge clk_i);
      if (data_req_o && data_gnt_i) begin
        check_flag("word aligned bus address", data_addr_o[1:0] == 2'b00, 1'b1);
        check_word("bus address", data_addr_o, {cur_addr[31:2], 2'b00} + 4 * n_gnt);
        check_be("byte enables", data_be_o, lane_enables(cur_addr, cur_size, n_gnt));
        check_flag("bus write enable", data_we_o, cur_we);
        n_gnt++;
        err = in_err_range(data_addr_o);
        if (data_we_o && !err) begin
          for (int b = 0; b < 4; b++) begin
            if (data_be_o[b]) mem[data_addr_o[7:2]][8*b +: 8] = data_wdata_o[8*b +: 8];
          end
        end
        ready = cyc + 1 + pick(3);           // 1 to 3 cycles after grant
        if (ready <= last_ready) ready = last_ready + 1; // keep order
        last_ready = ready;
        ready_q.push_back(ready);
        rdata_q.push_back(mem[data_addr_o[7:2]]);
        err_q.push_back(err);
        gnt_wait = pick(4);                   // delay for the next request
      end else if (data_req_o && gnt_wait > 0) begin
        gnt_wait--;
      end
      data_gnt_i <= (gnt_wait == 0);
      if (ready_q.size() != 0 && ready_q[0] == cyc + 1) begin
        void'(ready_q.pop_front());
        data_rvalid_i <= 1'b1;
        data_rdata_i  <= rdata_q.pop_front();
        data_err_i    <= err_q.pop_front();
      end else begin
        data_rvalid_i <= 1'b0;
        data_err_i    <= 1'b0;
      end
      cyc++;
    end
  end

  ////////////////////
  // response compare
  ////////////////////

  initial begin : compare
    logic exp_err;
    forever begin
      @(posedge clk_i);
      if (lsu_req_done_o) n_done++;
      if (lsu_resp_valid_o) begin
        exp_err = access_errors(cur_addr, cur_size);
        check_word("done pulses", n_done, 1);
        check_word("bus parts", n_gnt, part_count(cur_addr, cur_size));
        check_flag("load error", load_err_o, exp_err && !cur_we);
        check_flag("store error", store_err_o, exp_err && cur_we);
        check_flag("read data valid", lsu_rdata_valid_o, !exp_err && !cur_we);
        if (!cur_we && !exp_err) begin
          check_word("load data", lsu_rdata_o, loaded_value(cur_addr, cur_size, cur_sign));
        end
        if (cur_we) apply_store(cur_addr, cur_size, cur_wdata);
        n_done = 0;
        n_gnt  = 0;
      end else begin
        check_flag("pulse outside a response",
                   lsu_rdata_valid_o | load_err_o | store_err_o, 1'b0);
      end
    end
  end

  // one access that returns one cycle after its response
  task automatic run_access(input lsu_bus_pkg::bus_word_t a,
                            input lsu_op_pkg::access_size_e s, input logic we,
                            input lsu_bus_pkg::bus_word_t wd, input logic sign);
    cur_addr  = a;
    cur_size  = s;
    cur_we    = we;
    cur_wdata = wd;
    cur_sign  = sign;
    lsu_req_i      <= 1'b1;
    lsu_addr_i     <= a;
    lsu_size_i     <= s;
    lsu_we_i       <= we;
    lsu_wdata_i    <= wd;
    lsu_sign_ext_i <= sign;
    do @(posedge clk_i); while (!lsu_req_done_o);
    lsu_req_i <= 1'b0;
    do @(posedge clk_i); while (!lsu_resp_valid_o);
    @(posedge clk_i);
  endtask

  ////////////////////
  // stimulus
  ////////////////////

  initial begin : stimulus
    lsu_op_pkg::access_size_e sz;
    lsu_bus_pkg::bus_word_t   a;
    rst_ni         = 1'b0;
    data_gnt_i     = 1'b0;
    data_rvalid_i  = 1'b0;
    data_err_i     = 1'b0;
    data_rdata_i   = '0;
    lsu_req_i      = 1'b0;
    lsu_we_i       = 1'b0;
    lsu_size_i     = lsu_op_pkg::WORD;
    lsu_addr_i     = '0;
    lsu_wdata_i    = '0;
    lsu_sign_ext_i = 1'b0;
    for (int i = 0; i < 64; i++) begin
      mem[i]     = 32'h9e37_79b9 * (i + 1) ^ {4{8'(i * 37)}}; // plenty of set top bits
      exp_mem[i] = mem[i];
    end
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    check_flag("busy after reset", busy_o, 1'b0);
    check_flag("bus request after reset", data_req_o, 1'b0);
    check_flag("done after reset", lsu_req_done_o, 1'b0);
    check_flag("response after reset", lsu_resp_valid_o, 1'b0);

    // loads of every size, offset and extension with splits included
    for (int s = 0; s < 3; s++) begin
      for (int o = 0; o < 4; o++) begin
        for (int x = 0; x < 2; x++) begin
          sz = lsu_op_pkg::access_size_e'(s);
          run_access(32'h40 + 8 * (4 * s + o) + o, sz, 1'b0, '0, x[0]);
        end
      end
    end

    // stores of every size and offset and a read back of each
    for (int s = 0; s < 3; s++) begin
      for (int o = 0; o < 4; o++) begin
        sz = lsu_op_pkg::access_size_e'(s);
        a  = 32'h80 + 8 * (4 * s + o) + o;
        run_access(a, sz, 1'b1, $random(seed), 1'b0);
        run_access(a, sz, 1'b0, '0, 1'b0);
      end
    end

    for (int k = 0; k < N_RAND; k++) begin
      sz = lsu_op_pkg::access_size_e'(pick(3));
      a  = pick(32'he0);
      run_access(a, sz, pick(2) == 1, $random(seed), pick(2) == 1);
    end

    // accesses around the error range where either part may fail
    for (int s = 0; s < 3; s++) begin
      for (int i = 0; i < 5; i++) begin
        sz = lsu_op_pkg::access_size_e'(s);
        run_access(32'hec + 3 * i, sz, ((i + s) % 2) == 1, $random(seed), 1'b1);
      end
    end

    for (int i = 0; i < 64; i++) check_word("memory word", mem[i], exp_mem[i]);
    $display("Everything OK");
    $finish;
  end

endmodule
